// File: hdl/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    // branch compares
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load widths
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // store widths
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // integer ops, shared by OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl / sra by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra

    localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

endpackage

// File: hdl/uarch_pkg.sv
package uarch_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_e;

    typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jalr} pc_sel_e;

    typedef enum logic [1:0] {st_idle, st_running, st_halted} ctrl_state_e;

    localparam int mem_words  = 1024;
    localparam int mem_addr_w = 10;  // log2 of mem_words

    localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage

// File: hdl/core_ctrl.sv
module core_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic [isa_pkg::xlen-1:0] instr,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  logic                     branch_taken,
    input  logic [isa_pkg::xlen-1:0] rf_x10,
    input  logic [isa_pkg::xlen-1:0] rs1_data,
    input  logic [isa_pkg::xlen-1:0] rs2_data,
    input  logic [isa_pkg::xlen-1:0] alu_result,
    input  logic [isa_pkg::xlen-1:0] load_data,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [4:0]               rd,
    output logic [isa_pkg::xlen-1:0] alu_a,
    output logic [isa_pkg::xlen-1:0] alu_b,
    output uarch_pkg::alu_op_e       alu_op,
    output logic [isa_pkg::xlen-1:0] rd_wdata,
    output logic                     reg_we,
    output logic                     mem_re,
    output logic                     mem_we,
    output logic [2:0]               mem_funct3,
    output uarch_pkg::pc_sel_e       pc_sel,
    output logic [isa_pkg::xlen-1:0] branch_target,
    output logic                     advance,
    output logic                     halted,
    output logic                     illegal,
    output logic [isa_pkg::xlen-1:0] exit_code,
    output logic [isa_pkg::xlen-1:0] halt_pc
);
    import isa_pkg::*;
    import uarch_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [xlen-1:0] imm;
    alu_op_e         arith_op;
    logic            alu_src_imm;
    logic            alu_src_pc;
    wb_sel_e         wb_sel;
    pc_sel_e         dec_pc_sel;
    logic            dec_reg_we, dec_mem_we, dec_mem_re;
    logic            is_branch, is_ebreak, legal;
    ctrl_state_e     state_q;
    logic            running, halt_now;

    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7     = instr[31:25];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign rd         = instr[11:7];
    assign mem_funct3 = funct3;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // sub only for register form
    always_comb begin
        case (funct3)
            f3_add:  arith_op = (opcode == opc_op && instr[30]) ? alu_sub : alu_add;
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_sltu: arith_op = alu_sltu;
            f3_xor:  arith_op = alu_xor;
            f3_sr:   arith_op = instr[30] ? alu_sra : alu_srl;
            f3_or:   arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // ****************************************
    // decode
    // ****************************************
    always_comb begin
        imm         = imm_i;
        alu_op      = alu_add;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b0;
        wb_sel      = wb_alu;
        dec_pc_sel  = pc_plus4;
        dec_reg_we  = 1'b0;
        dec_mem_we  = 1'b0;
        dec_mem_re  = 1'b0;
        is_branch   = 1'b0;
        is_ebreak   = 1'b0;
        legal       = 1'b1;
        case (opcode)
            opc_lui: begin
                imm        = imm_u;
                alu_op     = alu_pass_b;
                dec_reg_we = 1'b1;
            end
            opc_auipc: begin
                imm        = imm_u;
                alu_src_pc = 1'b1;
                dec_reg_we = 1'b1;
            end
            opc_jal: begin
                imm        = imm_j;
                wb_sel     = wb_pc4;
                dec_pc_sel = pc_branch;  // pc + imm
                dec_reg_we = 1'b1;
            end
            opc_jalr: begin
                wb_sel     = wb_pc4;
                dec_pc_sel = pc_jalr;
                dec_reg_we = 1'b1;
                legal      = (funct3 == 3'b000);
            end
            opc_branch: begin
                imm         = imm_b;
                alu_src_imm = 1'b0;  // alu compares rs1 / rs2
                is_branch   = 1'b1;
                legal       = (funct3[2:1] != 2'b01);
            end
            opc_load: begin
                wb_sel     = wb_load;
                dec_reg_we = 1'b1;
                dec_mem_re = 1'b1;
                legal      = funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu};
            end
            opc_store: begin
                imm        = imm_s;
                dec_mem_we = 1'b1;
                legal      = funct3 inside {f3_sb, f3_sh, f3_sw};
            end
            opc_op_imm: begin
                alu_op     = arith_op;
                dec_reg_we = 1'b1;
                if (funct3 == f3_sll)
                    legal = (funct7 == f7_base);
                else if (funct3 == f3_sr)
                    legal = (funct7 == f7_base) || (funct7 == f7_alt);
            end
            opc_op: begin
                alu_op      = arith_op;
                alu_src_imm = 1'b0;
                dec_reg_we  = 1'b1;
                legal       = (funct7 == f7_base) ||
                              (funct7 == f7_alt && (funct3 == f3_add || funct3 == f3_sr));
            end
            opc_system: begin
                legal     = (instr == ebreak_word);  // no ecall or csr
                is_ebreak = legal;
            end
            default: legal = 1'b0;
        endcase
    end

    // ****************************************
    // datapath selects
    // ****************************************
    assign alu_a         = alu_src_pc ? pc : rs1_data;
    assign alu_b         = alu_src_imm ? imm : rs2_data;
    assign branch_target = pc + imm;
    assign pc_sel        = (is_branch && branch_taken) ? pc_branch : dec_pc_sel;

    always_comb begin
        case (wb_sel)
            wb_load: rd_wdata = load_data;
            wb_pc4:  rd_wdata = pc + 32'd4;
            default: rd_wdata = alu_result;
        endcase
    end

    // ****************************************
    // run / halt
    // ****************************************
    assign running  = (state_q == st_running);
    assign halted   = (state_q == st_halted);
    assign halt_now = running && (is_ebreak || !legal);
    assign advance  = running && !halt_now;  // pc parks on the halting word
    assign reg_we   = running && legal && dec_reg_we;
    assign mem_we   = running && legal && dec_mem_we;
    assign mem_re   = running && legal && dec_mem_re;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            illegal   <= 1'b0;
            exit_code <= '0;
            halt_pc   <= '0;
        end else begin
            case (state_q)
                st_idle: if (run) state_q <= st_running;
                st_running: begin
                    if (halt_now) begin
                        state_q   <= st_halted;
                        illegal   <= !legal;
                        exit_code <= rf_x10;
                        halt_pc   <= pc;
                    end
                end
                default: state_q <= st_halted;  // sticky until reset
            endcase
        end
    end

    // fetch holds the halting word
    a_pc_parked: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> pc == halt_pc);

endmodule

// File: hdl/fetch_unit.sv
module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     advance,
    input  uarch_pkg::pc_sel_e       pc_sel,
    input  logic [isa_pkg::xlen-1:0] branch_target,
    input  logic [isa_pkg::xlen-1:0] jalr_target,
    output logic [isa_pkg::xlen-1:0] pc
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (pc_sel)
            pc_branch: pc_next = branch_target;
            pc_jalr:   pc_next = {jalr_target[xlen-1:1], 1'b0};  // ISA clears bit 0
            default:   pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= reset_pc;
        else if (advance)
            pc <= pc_next;
    end

    // no compressed isa, targets must land on words
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     we,
    input  logic [isa_pkg::xlen-1:0] wdata,
    output logic [isa_pkg::xlen-1:0] rs1_data,
    output logic [isa_pkg::xlen-1:0] rs2_data,
    output logic [isa_pkg::xlen-1:0] x10
);
    import isa_pkg::*;

    logic [xlen-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign x10      = regs[10];  // a0, exit code

endmodule

// File: hdl/alu.sv
module alu (
    input  logic [isa_pkg::xlen-1:0] a,
    input  logic [isa_pkg::xlen-1:0] b,
    input  uarch_pkg::alu_op_e       alu_op,
    input  logic [2:0]               funct3_branch,
    output logic [isa_pkg::xlen-1:0] result,
    output logic                     branch_taken
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic [4:0] shamt;
    logic       eq, lt, ltu;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {31'b0, lt};
            alu_sltu:   result = {31'b0, ltu};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            default:    result = b;  // lui
        endcase
    end

    // compare path, independent of result
    always_comb begin
        case (funct3_branch)
            f3_beq:  branch_taken = eq;
            f3_bne:  branch_taken = !eq;
            f3_blt:  branch_taken = lt;
            f3_bge:  branch_taken = !lt;
            f3_bltu: branch_taken = ltu;
            f3_bgeu: branch_taken = !ltu;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/lsu.sv
module lsu (
    input  logic                             clk,
    input  logic [isa_pkg::xlen-1:0]         addr,
    input  logic [isa_pkg::xlen-1:0]         store_data,
    input  logic [2:0]                       funct3,
    input  logic                             re,
    input  logic                             we,
    input  logic [isa_pkg::xlen-1:0]         mem_rdata,
    output logic [uarch_pkg::mem_addr_w-1:0] word_addr,
    output logic [isa_pkg::xlen-1:0]         mem_wdata,
    output logic [3:0]                       mem_wmask,
    output logic                             mem_we,
    output logic [isa_pkg::xlen-1:0]         load_data
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic [1:0]      offset;
    logic [xlen-1:0] lane;
    logic            misaligned;

    assign offset    = addr[1:0];
    assign word_addr = addr[mem_addr_w+1:2];
    assign mem_we    = we;

    // replicate into every lane, mask picks the live one
    always_comb begin
        case (funct3)
            f3_sb: begin
                mem_wdata = {4{store_data[7:0]}};
                mem_wmask = 4'b0001 << offset;
            end
            f3_sh: begin
                mem_wdata = {2{store_data[15:0]}};
                mem_wmask = offset[1] ? 4'b1100 : 4'b0011;
            end
            f3_sw: begin
                mem_wdata = store_data;
                mem_wmask = 4'b1111;
            end
            default: begin
                mem_wdata = store_data;
                mem_wmask = 4'b0000;
            end
        endcase
    end

    assign lane = mem_rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            f3_lb:   load_data = {{24{lane[7]}}, lane[7:0]};
            f3_lh:   load_data = {{16{lane[15]}}, lane[15:0]};
            f3_lbu:  load_data = {24'b0, lane[7:0]};
            f3_lhu:  load_data = {16'b0, lane[15:0]};
            f3_lw:   load_data = mem_rdata;
            default: load_data = '0;
        endcase
    end

    assign misaligned = (funct3[1:0] == 2'b01 && offset[0]) ||
                        (funct3[1:0] == 2'b10 && offset != 2'b00);

    a_natural_align: assert property (@(posedge clk) (re || we) |-> !misaligned);

endmodule

// File: hdl/unified_mem.sv
module unified_mem (
    input  logic                             clk,
    input  logic [uarch_pkg::mem_addr_w-1:0] fetch_addr,
    input  logic [uarch_pkg::mem_addr_w-1:0] data_addr,
    input  logic [isa_pkg::xlen-1:0]         wdata,
    input  logic [3:0]                       wmask,
    input  logic                             we,
    input  logic                             load_en,
    input  logic [uarch_pkg::mem_addr_w-1:0] load_addr,
    input  logic [isa_pkg::xlen-1:0]         load_data,
    output logic [isa_pkg::xlen-1:0]         fetch_data,
    output logic [isa_pkg::xlen-1:0]         rdata
);

    logic [isa_pkg::xlen-1:0] mem [uarch_pkg::mem_words];

    // both read ports are combinational
    assign fetch_data = mem[fetch_addr];
    assign rdata      = mem[data_addr];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i])
                    mem[data_addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // preload and core stores must never overlap
    a_no_load_during_store: assert property (@(posedge clk) !(load_en && we));

endmodule

// File: hdl/cpu.sv
module cpu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            load_en,
    input  logic [uarch_pkg::mem_addr_w-1:0] load_addr,
    input  logic [isa_pkg::xlen-1:0]        load_data,
    output logic                            halted,
    output logic                            illegal,
    output logic [isa_pkg::xlen-1:0]        exit_code,
    output logic [isa_pkg::xlen-1:0]        halt_pc,
    output logic                            store_valid,
    output logic [isa_pkg::xlen-1:0]        store_addr,
    output logic [isa_pkg::xlen-1:0]        store_data,
    output logic [3:0]                      store_mask
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       instr;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       x10;
    logic [xlen-1:0]       alu_a;
    logic [xlen-1:0]       alu_b;
    alu_op_e               alu_op;
    logic [xlen-1:0]       alu_result;
    logic                  branch_taken;
    logic [xlen-1:0]       rd_wdata;
    logic                  reg_we;
    logic                  mem_re;
    logic                  mem_we_req;
    logic [2:0]            mem_funct3;
    pc_sel_e               pc_sel;
    logic [xlen-1:0]       branch_target;
    logic                  advance;
    logic [mem_addr_w-1:0] word_addr;
    logic [xlen-1:0]       mem_wdata;
    logic [3:0]            mem_wmask;
    logic                  mem_we;
    logic [xlen-1:0]       mem_rdata;
    logic [xlen-1:0]       lsu_load_data;

    core_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .instr        (instr),
        .pc           (pc),
        .branch_taken (branch_taken),
        .rf_x10       (x10),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .load_data    (lsu_load_data),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_op       (alu_op),
        .rd_wdata     (rd_wdata),
        .reg_we       (reg_we),
        .mem_re       (mem_re),
        .mem_we       (mem_we_req),
        .mem_funct3   (mem_funct3),
        .pc_sel       (pc_sel),
        .branch_target(branch_target),
        .advance      (advance),
        .halted       (halted),
        .illegal      (illegal),
        .exit_code    (exit_code),
        .halt_pc      (halt_pc)
    );

    fetch_unit fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .advance      (advance),
        .pc_sel       (pc_sel),
        .branch_target(branch_target),
        .jalr_target  (alu_result),
        .pc           (pc)
    );

    reg_file rf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .we      (reg_we),
        .wdata   (rd_wdata),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .x10     (x10)
    );

    alu alu_i (
        .a            (alu_a),
        .b            (alu_b),
        .alu_op       (alu_op),
        .funct3_branch(mem_funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    lsu lsu_i (
        .clk       (clk),
        .addr      (alu_result),
        .store_data(rs2_data),
        .funct3    (mem_funct3),
        .re        (mem_re),
        .we        (mem_we_req),
        .mem_rdata (mem_rdata),
        .word_addr (word_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_we    (mem_we),
        .load_data (lsu_load_data)
    );

    unified_mem mem_i (
        .clk       (clk),
        .fetch_addr(pc[mem_addr_w+1:2]),
        .data_addr (word_addr),
        .wdata     (mem_wdata),
        .wmask     (mem_wmask),
        .we        (mem_we),
        .load_en   (load_en & ~run),  // preload only before start
        .load_addr (load_addr),
        .load_data (load_data),
        .fetch_data(instr),
        .rdata     (mem_rdata)
    );

    // store observation
    assign store_valid = mem_we;
    assign store_addr  = {alu_result[xlen-1:2], 2'b00};
    assign store_data  = mem_wdata;
    assign store_mask  = mem_wmask;

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // low for 4 cycles at start and again on each request
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            @(posedge reset_req);
            rst_n = 1'b0;
        end
    end

endmodule

// File: verif/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int gold_words  = 256;
    localparam int run_limit   = 500;  // cycles per program
    localparam int reset_limit = 16;

    logic                  clk;
    logic                  rst_n;
    logic                  reset_req;
    logic                  run;
    logic                  load_en;
    logic [mem_addr_w-1:0] load_addr;
    logic [xlen-1:0]       load_data;
    logic                  halted;
    logic                  illegal;
    logic [xlen-1:0]       exit_code;
    logic [xlen-1:0]       halt_pc;
    logic                  store_valid;
    logic [xlen-1:0]       store_addr;
    logic [xlen-1:0]       store_data;
    logic [3:0]            store_mask;

    logic [31:0] gold [gold_words];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] exp_mask_q [$];
    int          checks_done;

    tb_clock_gen clk_gen_i (
        .reset_req(reset_req),
        .clk      (clk),
        .rst_n    (rst_n)
    );

    cpu dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .halted     (halted),
        .illegal    (illegal),
        .exit_code  (exit_code),
        .halt_pc    (halt_pc),
        .store_valid(store_valid),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_mask (store_mask)
    );

    // ****************************************
    // helpers
    // ****************************************
    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks_done++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_reset_release;
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);  // rst_n moves on the falling edge
            cycles++;
        end while (!rst_n && cycles < reset_limit);
        if (!rst_n)
            abort_run("reset was never released");
        else begin
            @(negedge clk);
            check_value("halted", halted, 0);
            check_value("illegal", illegal, 0);
            check_value("store_valid", store_valid, 0);
        end
    endtask

    task automatic restart_core;
        @(negedge clk);
        run       = 1'b0;
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        wait_reset_release();
    endtask

    task automatic preload_word(input logic [31:0] byte_addr, input logic [31:0] word);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = byte_addr[mem_addr_w+1:2];
        load_data = word;
    endtask

    task automatic match_store;
        if (exp_addr_q.size() == 0)
            abort_run("the core stored more often than expected");
        else begin
            check_value("store_addr", store_addr, exp_addr_q.pop_front());
            check_value("store_data", store_data, exp_data_q.pop_front());
            check_value("store_mask", store_mask, exp_mask_q.pop_front());
        end
    endtask

    task automatic run_program(input logic [31:0] exp_exit, input logic [31:0] exp_pc,
                               input logic [31:0] exp_illegal);
        int cycles;
        cycles = 0;
        @(negedge clk);
        load_en = 1'b0;
        run     = 1'b1;
        while (!halted && cycles < run_limit) begin
            @(negedge clk);  // outputs settled, next edge not yet taken
            cycles++;
            if (store_valid)
                match_store();
        end
        if (!halted)
            abort_run("the core did not halt within the cycle limit");
        else if (exp_addr_q.size() != 0)
            abort_run("the core halted before all expected stores");
        else begin
            check_value("illegal", illegal, exp_illegal);
            check_value("exit_code", exit_code, exp_exit);
            check_value("halt_pc", halt_pc, exp_pc);
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        int  idx;
        bit  finished;
        run         = 1'b0;
        reset_req   = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        checks_done = 0;
        idx         = 0;
        finished    = 1'b0;
        $readmemh("verif/cpu_golden.txt", gold);
        wait_reset_release();

        while (!finished) begin
            if (idx > gold_words - 4)
                abort_run("golden file has no end record");
            else begin
                case (gold[idx])
                    32'h0: finished = 1'b1;
                    32'h1: begin
                        preload_word(gold[idx+1], gold[idx+2]);
                        idx += 3;
                    end
                    32'h2: begin
                        exp_addr_q.push_back(gold[idx+1]);
                        exp_data_q.push_back(gold[idx+2]);
                        exp_mask_q.push_back(gold[idx+3]);
                        idx += 4;
                    end
                    32'h3: begin
                        run_program(gold[idx+1], gold[idx+2], gold[idx+3]);
                        idx += 4;
                    end
                    32'h4: begin
                        restart_core();  // fresh reset between programs
                        idx += 1;
                    end
                    default: abort_run("unknown record tag in golden file");
                endcase
            end
        end

        if (checks_done > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("ERROR: no checks were made, golden file looks empty");
            $display("** FAIL **");
            $fatal(1, "empty run");
        end
    end

endmodule

// File: files.f
hdl/isa_pkg.sv
hdl/uarch_pkg.sv
hdl/core_ctrl.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/lsu.sv
hdl/unified_mem.sv
hdl/cpu.sv
verif/tb_clock_gen.sv
verif/tb_cpu.sv

// File: verif/cpu_golden.txt
// tag 1: program word <byte addr> <instr>   tag 2: expected store <addr> <lane data> <mask>
// tag 3: run, expect <x10> <halt pc> <illegal>   tag 4: fresh reset   tag 0: end
1 000 40000093 // addi x1, x0, 0x400
1 004 12345137 // lui x2, 0x12345
1 008 67810113 // addi x2, x2, 0x678
1 00c 0020a023 // sw x2, 0(x1)
1 010 f8000193 // addi x3, x0, -128
1 014 003082a3 // sb x3, 5(x1)
1 018 fff14213 // xori x4, x2, -1
1 01c 00409323 // sh x4, 6(x1)
1 020 00508283 // lb x5, 5(x1)
1 024 0050c303 // lbu x6, 5(x1)
1 028 00609383 // lh x7, 6(x1)
1 02c 0060d403 // lhu x8, 6(x1)
1 030 008284b3 // add x9, x5, x8
1 034 407305b3 // sub x11, x6, x7
1 038 0090a423 // sw x9, 8(x1)
1 03c 00b0a623 // sw x11, 12(x1)
1 040 4043d613 // srai x12, x7, 4
1 044 0063a6b3 // slt x13, x7, x6
1 048 00733733 // sltu x14, x6, x7
1 04c 00871713 // slli x14, x14, 8
1 050 00d667b3 // or x15, x12, x13
1 054 00e7c7b3 // xor x15, x15, x14
1 058 00f0a823 // sw x15, 16(x1)
1 05c 00e68e63 // beq x13, x14, 0x78 (not taken)
1 060 00069463 // bne x13, x0, 0x68 (taken)
1 064 0000a023 // sw x0, 0(x1) skipped
1 068 0140086f // jal x16, 0x7c
1 06c 00d09a23 // sh x13, 20(x1)
1 070 00780513 // addi x10, x16, 7
1 074 00100073 // ebreak
1 078 0000a423 // sw x0, 8(x1) skipped
1 07c 0063c463 // blt x7, x6, 0x84 (taken)
1 080 0000a623 // sw x0, 12(x1) skipped
1 084 fe737ae3 // bgeu x6, x7, 0x78 (not taken)
1 088 fe63d8e3 // bge x7, x6, 0x78 (not taken)
1 08c 00180067 // jalr x0, 1(x16) back to 0x6c
2 00000400 12345678 f
2 00000404 80808080 2
2 00000404 a987a987 c
2 00000408 0000a907 f
2 0000040c 000056f9 f
2 00000410 fffffb99 f
2 00000414 00010001 3
3 00000073 00000074 0
4
// second program halts on an undefined opcode
1 000 00500513 // addi x10, x0, 5
1 004 0000007f // opcode 7f is not RV32I
3 00000005 00000004 1
0
